// ==== design/can_bit_timer.sv ====
`default_nettype none

module can_bit_timer #(
    parameter int divider = 54
) (
    input  logic clk,
    input  logic rst_n,
    output logic bit_tick,
    output logic sample_tick
);

    localparam int cnt_w = $clog2(divider + 2);

    logic [cnt_w-1:0] cnt;

    // One bit period is divider+1 clocks.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= cnt_w'(divider);
        end else if (cnt == '0) begin
            cnt <= cnt_w'(divider);
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign bit_tick = (cnt == '0);

    // Sampling sits near the middle of the bit, away from both edges.
    assign sample_tick = (cnt == cnt_w'(divider / 2));

endmodule

`default_nettype wire

// ==== design/can_crc15.sv ====
`default_nettype none

module can_crc15 (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             crc_clear,
    input  logic                             crc_en,
    input  logic                             crc_bit,
    output logic [can_pkg::can_crc_width-1:0] crc_value
);

    localparam int w = can_pkg::can_crc_width;

    logic feedback;

    assign feedback = crc_value[w-1] ^ crc_bit;

    // Serial LFSR, one bit per enable, clear wins over enable.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_value <= '0;
        end else if (crc_clear) begin
            crc_value <= '0;
        end else if (crc_en) begin
            crc_value <= {crc_value[w-2:0], 1'b0} ^ (feedback ? can_pkg::can_crc_poly : '0);
        end
    end

endmodule

`default_nettype wire

// ==== design/can_node.sv ====
`default_nettype none

module can_node #(
    parameter int divider    = 54,
    parameter int data_bytes = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [can_pkg::can_id_width-1:0]  tx_id,
    input  logic [can_pkg::can_dlc_width-1:0] tx_dlc,
    input  logic [data_bytes*8-1:0]           tx_data,
    input  logic                              rx_line,
    output logic                              tx_line,
    output logic                              busy,
    output logic [can_pkg::can_id_width-1:0]  rx_id,
    output logic [can_pkg::can_dlc_width-1:0] rx_dlc,
    output logic [data_bytes*8-1:0]           rx_data,
    output logic                              rx_valid,
    output logic                              rx_error
);

    logic                              bit_tick;
    logic                              sample_tick;
    logic                              tx_crc_clear;
    logic                              tx_crc_en;
    logic                              tx_crc_bit;
    logic [can_pkg::can_crc_width-1:0] tx_crc_value;
    logic                              rx_crc_clear;
    logic                              rx_crc_en;
    logic                              rx_crc_bit;
    logic [can_pkg::can_crc_width-1:0] rx_crc_value;

    can_bit_timer #(
        .divider (divider)
    ) can_bit_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_tick    (bit_tick),
        .sample_tick (sample_tick)
    );

    can_tx_framer #(
        .data_bytes (data_bytes)
    ) can_tx_framer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bit_tick  (bit_tick),
        .start     (start),
        .tx_id     (tx_id),
        .tx_dlc    (tx_dlc),
        .tx_data   (tx_data),
        .crc_value (tx_crc_value),
        .crc_clear (tx_crc_clear),
        .crc_en    (tx_crc_en),
        .crc_bit   (tx_crc_bit),
        .tx_line   (tx_line),
        .busy      (busy)
    );

    can_crc15 tx_crc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .crc_clear (tx_crc_clear),
        .crc_en    (tx_crc_en),
        .crc_bit   (tx_crc_bit),
        .crc_value (tx_crc_value)
    );

    // The receiver keeps its own CRC so that loopback checks the full path.
    can_rx_deframer #(
        .data_bytes (data_bytes)
    ) can_rx_deframer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .rx_line     (rx_line),
        .crc_value   (rx_crc_value),
        .crc_clear   (rx_crc_clear),
        .crc_en      (rx_crc_en),
        .crc_bit     (rx_crc_bit),
        .rx_id       (rx_id),
        .rx_dlc      (rx_dlc),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_error    (rx_error)
    );

    can_crc15 rx_crc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .crc_clear (rx_crc_clear),
        .crc_en    (rx_crc_en),
        .crc_bit   (rx_crc_bit),
        .crc_value (rx_crc_value)
    );

endmodule

`default_nettype wire

// ==== design/can_pkg.sv ====
`default_nettype none

package can_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field widths of a CAN 2.0A data frame.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int can_id_width  = 11;
    localparam int can_dlc_width = 4;
    localparam int can_crc_width = 15;

    // Identifier, RTR, IDE, r0 and DLC.
    localparam int can_hdr_bits = can_id_width + 3 + can_dlc_width;

    localparam logic [can_crc_width-1:0] can_crc_poly = 15'h4599;

    // A complement bit follows this many equal bits.
    localparam int can_stuff_limit = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Recessive frame tail.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int can_ack_bits = 2;
    localparam int can_eof_bits = 11;

endpackage

`default_nettype wire

// ==== design/can_rx_deframer.sv ====
`default_nettype none

module can_rx_deframer #(
    parameter int data_bytes = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sample_tick,
    input  logic                              rx_line,
    input  logic [can_pkg::can_crc_width-1:0] crc_value,
    output logic                              crc_clear,
    output logic                              crc_en,
    output logic                              crc_bit,
    output logic [can_pkg::can_id_width-1:0]  rx_id,
    output logic [can_pkg::can_dlc_width-1:0] rx_dlc,
    output logic [data_bytes*8-1:0]           rx_data,
    output logic                              rx_valid,
    output logic                              rx_error
);

    localparam int data_bits    = data_bytes * 8;
    localparam int crc_w        = can_pkg::can_crc_width;
    localparam int payload_bits = can_pkg::can_hdr_bits + data_bits;
    localparam int field_bits   = payload_bits + crc_w;
    localparam int send_bits    = field_bits + 1;
    localparam int idx_w        = $clog2(send_bits + 1);
    localparam int limit        = can_pkg::can_stuff_limit;

    // Bit positions in field_q once the CRC has been shifted in.
    localparam int dlc_lsb = crc_w + data_bits;
    localparam int ctl_lsb = dlc_lsb + can_pkg::can_dlc_width;
    localparam int id_lsb  = ctl_lsb + 3;

    localparam logic [limit-1:0] hist_sof = {{(limit - 1){1'b1}}, 1'b0};

    typedef enum logic {
        st_idle,
        st_recv
    } state_t;

    state_t                  state;
    logic [idx_w-1:0]        bit_idx;
    logic [limit-1:0]        hist;
    logic [field_bits-1:0]   field_q;
    logic                    recv_tick;
    logic                    stuff;
    logic                    stuff_bad;
    logic                    in_payload;
    logic                    last_bit;
    logic                    frame_ok;

    assign recv_tick  = sample_tick && (state == st_recv);
    assign stuff      = (&hist) | (~|hist);
    assign stuff_bad  = stuff && (rx_line == hist[0]);
    assign in_payload = (bit_idx < idx_w'(payload_bits));
    assign last_bit   = (bit_idx == idx_w'(send_bits - 1));

    // Only evaluated while rx_line carries the CRC delimiter.
    assign frame_ok = (field_q[ctl_lsb +: 3] == 3'b000) &&
                      (field_q[crc_w-1:0] == crc_value) && rx_line;

    assign crc_clear = sample_tick && (state == st_idle) && !rx_line;
    assign crc_en    = recv_tick && !stuff && in_payload;
    assign crc_bit   = rx_line;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field capture.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (recv_tick && !stuff && !last_bit) begin
            field_q <= {field_q[field_bits-2:0], rx_line};
        end
        if (recv_tick && !stuff && last_bit && frame_ok) begin
            rx_id   <= field_q[id_lsb +: can_pkg::can_id_width];
            rx_dlc  <= field_q[dlc_lsb +: can_pkg::can_dlc_width];
            rx_data <= field_q[crc_w +: data_bits];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Destuffing and frame checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            bit_idx  <= '0;
            hist     <= '1;
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            case (state)
                st_idle: begin
                    if (sample_tick && !rx_line) begin
                        hist    <= hist_sof;
                        bit_idx <= '0;
                        state   <= st_recv;
                    end
                end
                st_recv: begin
                    if (sample_tick) begin
                        hist <= {hist[limit-2:0], rx_line};
                        if (stuff_bad) begin
                            rx_error <= 1'b1;
                            state    <= st_idle;
                        end else if (!stuff) begin
                            if (last_bit) begin
                                rx_valid <= frame_ok;
                                rx_error <= !frame_ok;
                                state    <= st_idle;
                            end else begin
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/can_tx_framer.sv ====
`default_nettype none

module can_tx_framer #(
    parameter int data_bytes = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              bit_tick,
    input  logic                              start,
    input  logic [can_pkg::can_id_width-1:0]  tx_id,
    input  logic [can_pkg::can_dlc_width-1:0] tx_dlc,
    input  logic [data_bytes*8-1:0]           tx_data,
    input  logic [can_pkg::can_crc_width-1:0] crc_value,
    output logic                              crc_clear,
    output logic                              crc_en,
    output logic                              crc_bit,
    output logic                              tx_line,
    output logic                              busy
);

    localparam int data_bits    = data_bytes * 8;
    localparam int payload_bits = can_pkg::can_hdr_bits + data_bits;
    localparam int send_bits    = payload_bits + can_pkg::can_crc_width + 1;
    localparam int idx_w        = $clog2(send_bits + 1);
    localparam int tail_w       = $clog2(can_pkg::can_crc_width + 1);
    localparam int limit        = can_pkg::can_stuff_limit;

    // History right after SOF: idle recessive bits, then the dominant SOF.
    localparam logic [limit-1:0] hist_sof = {{(limit - 1){1'b1}}, 1'b0};

    typedef enum logic [2:0] {
        st_idle,
        st_sof,
        st_send,
        st_ack,
        st_eof
    } state_t;

    state_t                          state;
    logic [idx_w-1:0]                bit_idx;
    logic [limit-1:0]                hist;
    logic [payload_bits-1:0]         frame_q;
    logic [can_pkg::can_crc_width:0] tail;
    logic [idx_w-1:0]                tail_pos;
    logic                            in_payload;
    logic                            stuff;
    logic                            line_bit;
    logic                            send_tick;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next bit on the line.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit_idx counts frame bits only, stuff bits do not advance it.
    assign in_payload = (bit_idx < idx_w'(payload_bits));
    assign tail       = {crc_value, 1'b1};
    assign tail_pos   = idx_w'(send_bits - 1) - bit_idx;
    assign stuff      = (&hist) | (~|hist);

    // The CRC is complete once the last data bit has been clocked in.
    always_comb begin
        if (stuff) begin
            line_bit = ~hist[0];
        end else if (in_payload) begin
            line_bit = frame_q[payload_bits-1];
        end else begin
            line_bit = tail[tail_pos[tail_w-1:0]];
        end
    end

    assign send_tick = bit_tick && (state == st_send);
    assign crc_clear = bit_tick && (state == st_sof);
    assign crc_en    = send_tick && !stuff && in_payload;
    assign crc_bit   = line_bit;
    assign busy      = (state != st_idle);

    // RTR, IDE and r0 go out dominant.
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            frame_q <= {tx_id, 3'b000, tx_dlc, tx_data};
        end else if (send_tick && !stuff) begin
            frame_q <= {frame_q[payload_bits-2:0], 1'b0};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame sequencer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_idx <= '0;
            hist    <= '1;
            tx_line <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_sof;
                    end
                end
                st_sof: begin
                    if (bit_tick) begin
                        tx_line <= 1'b0;
                        hist    <= hist_sof;
                        bit_idx <= '0;
                        state   <= st_send;
                    end
                end
                st_send: begin
                    if (bit_tick) begin
                        tx_line <= line_bit;
                        hist    <= {hist[limit-2:0], line_bit};
                        if (!stuff) begin
                            if (bit_idx == idx_w'(send_bits - 1)) begin
                                bit_idx <= '0;
                                state   <= st_ack;
                            end else begin
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end
                    end
                end
                st_ack: begin
                    if (bit_tick) begin
                        tx_line <= 1'b1;
                        if (bit_idx == idx_w'(can_pkg::can_ack_bits - 1)) begin
                            bit_idx <= '0;
                            state   <= st_eof;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                st_eof: begin
                    // The extra tick ends the last EOF bit.
                    if (bit_tick) begin
                        tx_line <= 1'b1;
                        if (bit_idx == idx_w'(can_pkg::can_eof_bits)) begin
                            state <= st_idle;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dv/can_tb.sv ====
`default_nettype none

module can_tb;

    localparam int divider    = 9;
    localparam int data_bytes = 4;
    localparam int data_bits  = data_bytes * 8;
    localparam int pay_bits   = can_pkg::can_hdr_bits + data_bits;
    localparam int raw_bits   = pay_bits + can_pkg::can_crc_width + 1;
    localparam int max_bits   = 128;
    localparam int bit_clocks = divider + 1;
    localparam int timeout    = 4000;

    logic                              clk;
    logic                              rst_n;
    logic                              start;
    logic [can_pkg::can_id_width-1:0]  tx_id;
    logic [can_pkg::can_dlc_width-1:0] tx_dlc;
    logic [data_bits-1:0]              tx_data;
    logic                              rx_line;
    logic                              tx_line;
    logic                              busy;
    logic [can_pkg::can_id_width-1:0]  rx_id;
    logic [can_pkg::can_dlc_width-1:0] rx_dlc;
    logic [data_bits-1:0]              rx_data;
    logic                              rx_valid;
    logic                              rx_error;

    // The expected frame is written before each start and read by the checkers.
    logic [max_bits-1:0]               exp_bits;
    int                                exp_len;
    int                                exp_delim;
    int                                exp_data_idx;
    logic [can_pkg::can_id_width-1:0]  exp_id;
    logic [can_pkg::can_dlc_width-1:0] exp_dlc;
    logic [data_bits-1:0]              exp_data;

    int   errors;
    int   checks;
    int   seed;
    int   valid_seen;
    int   error_seen;
    logic timed_out;
    logic flip;
    logic corrupt_on;
    int   corrupt_idx;
    logic mon_active;
    logic mon_done;
    int   mon_phase;
    int   mon_bit;
    logic run_val;
    int   run_len;

    // The receive line follows tx_line and inverts one bit period when corruption is armed.
    assign rx_line = tx_line ^ flip;

    can_node #(
        .divider    (divider),
        .data_bytes (data_bytes)
    ) can_node_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .tx_id    (tx_id),
        .tx_dlc   (tx_dlc),
        .tx_data  (tx_data),
        .rx_line  (rx_line),
        .tx_line  (tx_line),
        .busy     (busy),
        .rx_id    (rx_id),
        .rx_dlc   (rx_dlc),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // SOF is dominant and leaves a zero CRC unchanged, so it is skipped.
    function automatic logic [can_pkg::can_crc_width-1:0] crc15_ref(
        input logic [pay_bits-1:0] payload
    );
        logic [can_pkg::can_crc_width-1:0] crc;
        logic                              fb;
        int                                i;
        crc = '0;
        for (i = pay_bits - 1; i >= 0; i--) begin
            fb  = crc[can_pkg::can_crc_width-1] ^ payload[i];
            crc = {crc[can_pkg::can_crc_width-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ can_pkg::can_crc_poly;
            end
        end
        return crc;
    endfunction

    // Builds the whole frame as it appears on the line and returns its length in bits.
    function automatic int stuffed_frame(
        input  logic [can_pkg::can_id_width-1:0]  id,
        input  logic [can_pkg::can_dlc_width-1:0] dlc,
        input  logic [data_bits-1:0]              data,
        output logic [max_bits-1:0]               bits,
        output int                                delim_idx,
        output int                                data_idx
    );
        logic [raw_bits-1:0] raw;
        logic                last;
        logic                b;
        int                  run;
        int                  n;
        int                  i;
        raw       = {id, 3'b000, dlc, data, crc15_ref({id, 3'b000, dlc, data}), 1'b1};
        bits      = '1;
        bits[0]   = 1'b0;
        last      = 1'b0;
        run       = 1;
        n         = 1;
        delim_idx = 0;
        data_idx  = 0;
        for (i = 0; i < raw_bits; i++) begin
            if (run == can_pkg::can_stuff_limit) begin
                bits[n] = ~last;
                last    = ~last;
                run     = 1;
                n++;
            end
            if (i == can_pkg::can_hdr_bits) begin
                data_idx = n;
            end
            if (i == raw_bits - 1) begin
                delim_idx = n;
            end
            b       = raw[raw_bits-1-i];
            bits[n] = b;
            if (b == last) begin
                run++;
            end else begin
                last = b;
                run  = 1;
            end
            n++;
        end
        // ACK and EOF stay recessive from the fill above.
        return n + can_pkg::can_ack_bits + can_pkg::can_eof_bits;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[FAIL] t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit monitor and receive checker.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst_n) begin
            mon_active = 1'b0;
            flip       = 1'b0;
        end else begin
            if (mon_active) begin
                if (mon_phase == bit_clocks - 1) begin
                    mon_phase = 0;
                    mon_bit   = mon_bit + 1;
                end else begin
                    mon_phase = mon_phase + 1;
                end
            end else if (busy && !tx_line) begin
                mon_active = 1'b1;
                mon_phase  = 0;
                mon_bit    = 0;
            end
            // Busy falls on the edge that ends the last EOF bit.
            if (mon_active && mon_phase == 0) begin
                if (!busy) begin
                    checks++;
                    if (mon_bit != exp_len) begin
                        report_mismatch("frame_length", 32'(exp_len), 32'(mon_bit));
                    end
                    mon_active = 1'b0;
                    mon_done   = 1'b1;
                    flip       = 1'b0;
                end else begin
                    flip = corrupt_on && (mon_bit == corrupt_idx);
                end
            end
            if (mon_active && mon_phase == bit_clocks / 2) begin
                if (mon_bit < exp_len) begin
                    checks++;
                    if (tx_line !== exp_bits[mon_bit]) begin
                        report_mismatch("tx_line", 32'(exp_bits[mon_bit]), 32'(tx_line));
                    end
                end
                if (mon_bit < exp_delim) begin
                    if (mon_bit == 0 || tx_line != run_val) begin
                        run_val = tx_line;
                        run_len = 1;
                    end else begin
                        run_len++;
                        if (run_len == can_pkg::can_stuff_limit + 1) begin
                            errors++;
                            $display("Six equal bits on tx_line before the CRC delimiter, bit %0d",
                                     mon_bit);
                        end
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && rx_valid) begin
            valid_seen++;
            checks++;
            if (rx_id !== exp_id) begin
                report_mismatch("rx_id", 32'(exp_id), 32'(rx_id));
            end
            if (rx_dlc !== exp_dlc) begin
                report_mismatch("rx_dlc", 32'(exp_dlc), 32'(rx_dlc));
            end
            if (rx_data !== exp_data) begin
                report_mismatch("rx_data", exp_data, rx_data);
            end
        end
        if (rst_n && rx_error) begin
            error_seen++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_for_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < timeout) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: busy did not reach %0b within %0d cycles", level, timeout);
        end
    endtask

    task automatic wait_for_monitor();
        int n;
        n = 0;
        while (!mon_done && n < timeout) begin
            @(negedge clk);
            n++;
        end
        if (!mon_done) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: the transmit monitor never saw the end of the frame");
        end
    endtask

    task automatic send_frame(
        input logic [can_pkg::can_id_width-1:0]  id,
        input logic [can_pkg::can_dlc_width-1:0] dlc,
        input logic [data_bits-1:0]              data,
        input logic                              poke,
        input logic                              corrupt
    );
        int n;
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        tx_id       = id;
        tx_dlc      = dlc;
        tx_data     = data;
        exp_id      = id;
        exp_dlc     = dlc;
        exp_data    = data;
        exp_len     = stuffed_frame(id, dlc, data, exp_bits, exp_delim, exp_data_idx);
        corrupt_idx = exp_data_idx + 7;
        corrupt_on  = corrupt;
        valid_seen  = 0;
        error_seen  = 0;
        mon_done    = 1'b0;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_for_busy(1'b1);
        if (timed_out) begin
            return;
        end
        if (poke) begin
            repeat (20 * bit_clocks) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_for_busy(1'b0);
        if (timed_out) begin
            return;
        end
        wait_for_monitor();
        if (timed_out) begin
            return;
        end
        checks++;
        if (corrupt) begin
            if (valid_seen != 0 || error_seen == 0) begin
                errors++;
                $display("Corrupted frame gave %0d rx_valid and %0d rx_error pulses",
                         valid_seen, error_seen);
            end
        end else begin
            if (valid_seen != 1) begin
                report_mismatch("rx_valid_count", 32'd1, 32'(valid_seen));
            end
            if (error_seen != 0) begin
                report_mismatch("rx_error_count", 32'd0, 32'(error_seen));
            end
        end
        // A start seen during busy must not launch a second frame.
        if (poke) begin
            for (n = 0; n < 3 * bit_clocks; n++) begin
                @(negedge clk);
                if (busy) begin
                    errors++;
                    $display("A start pulse given during busy launched another frame");
                    break;
                end
            end
        end
        corrupt_on = 1'b0;
    endtask

    initial begin
        int          f;
        logic [31:0] r;
        logic [31:0] d;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        tx_id       = '0;
        tx_dlc      = '0;
        tx_data     = '0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h6773;
        timed_out   = 1'b0;
        flip        = 1'b0;
        corrupt_on  = 1'b0;
        corrupt_idx = -1;
        mon_active  = 1'b0;
        mon_done    = 1'b0;
        mon_phase   = 0;
        mon_bit     = 0;
        run_val     = 1'b1;
        run_len     = 0;
        exp_len     = 0;
        exp_delim   = 0;
        valid_seen  = 0;
        error_seen  = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        if (tx_line !== 1'b1) begin
            report_mismatch("tx_line", 32'd1, 32'(tx_line));
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy", 32'd0, 32'(busy));
        end
        if (rx_valid !== 1'b0) begin
            report_mismatch("rx_valid", 32'd0, 32'(rx_valid));
        end
        if (rx_error !== 1'b0) begin
            report_mismatch("rx_error", 32'd0, 32'(rx_error));
        end
        for (f = 0; f < 20; f++) begin
            r = $random(seed);
            d = $random(seed);
            send_frame(r[10:0], r[14:11], d, 1'b0, 1'b0);
        end
        // Long runs of equal bits give the most stuff bits.
        send_frame('0, '0, '0, 1'b0, 1'b0);
        send_frame('1, '1, '1, 1'b0, 1'b0);
        r = $random(seed);
        d = $random(seed);
        send_frame(r[10:0], r[14:11], d, 1'b1, 1'b0);
        // Alternating data keeps the flipped bit clear of the stuff rule.
        send_frame(11'h2a5, 4'h4, 32'h5555_5555, 1'b0, 1'b1);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --top-module can_tb -f sources.f \
    -Mdir "$build_dir" -o can_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/can_tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$log_file"; then
    echo "Simulation reported failing checks, see $log_file"
    exit 1
fi

echo "Simulation finished without failing checks"
exit 0

// ==== sources.f ====
design/can_pkg.sv
design/can_bit_timer.sv
design/can_crc15.sv
design/can_tx_framer.sv
design/can_rx_deframer.sv
design/can_node.sv
dv/can_tb.sv
